// File: verilog/controlPkg.sv
package controlPkg;

    // Instruction field widths
    localparam int funct3Width = 3;
    localparam int funct7Width = 7;

    // RV32I major opcodes handled by the sequencer
    typedef enum logic [6:0] {
        opRtype  = 7'b0110011,
        opItype  = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    // Sequencer states, one per clock
    typedef enum logic [4:0] {
        fetch          = 5'b00000,
        decode         = 5'b00001,
        rtypeExec      = 5'b00010,
        aluWriteback   = 5'b00011,
        jalExec        = 5'b00100,
        branchComplete = 5'b00101,
        memAddr        = 5'b00110,
        loadAccess     = 5'b00111,
        loadWriteback  = 5'b01000,
        storeAccess    = 5'b01001,
        immExec        = 5'b01010,
        jalrExec       = 5'b01011,
        jalrLink       = 5'b01100,
        luiWriteback   = 5'b01101,
        auipcExec      = 5'b01110,
        fetchWait      = 5'b01111, // Synchronous memory read of the instruction
        loadWait       = 5'b10000,
        jalLink        = 5'b10001,
        decodeWait     = 5'b10010  // Register file read delay
    } stateT;

    // Operation class handed to the ALU decoder
    typedef enum logic [1:0] {
        aluAdd    = 2'b00,
        aluBranch = 2'b01,
        aluRegReg = 2'b10,
        aluRegImm = 2'b11
    } aluOpT;

    // ALU function codes as the datapath ALU expects them
    typedef enum logic [3:0] {
        funcAdd  = 4'b0000,
        funcSub  = 4'b0001,
        funcAnd  = 4'b0010,
        funcOr   = 4'b0011,
        funcXor  = 4'b0100,
        funcSll  = 4'b0101,
        funcSrl  = 4'b0110,
        funcSra  = 4'b0111,
        funcSltu = 4'b1000, // Also BLTU compare
        funcGeu  = 4'b1001,
        funcSlli = 4'b1010,
        funcSrli = 4'b1011,
        funcSrai = 4'b1100,
        funcSlt  = 4'b1101, // Also BLT compare
        funcGe   = 4'b1110
    } aluFuncT;

    typedef enum logic [1:0] {
        srcAPc    = 2'b00,
        srcAOldPc = 2'b01,
        srcARegA  = 2'b10
    } srcASelT;

    typedef enum logic [1:0] {
        srcBRegB = 2'b00,
        srcBImm  = 2'b01,
        srcBFour = 2'b10
    } srcBSelT;

    // Result bus sources
    typedef enum logic [2:0] {
        resultAluOut    = 3'b000, // Registered ALU output
        resultMemData   = 3'b001,
        resultAluResult = 3'b010, // Live ALU result
        resultImm       = 3'b011
    } resultSelT;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immU = 3'b011,
        immJ = 3'b100
    } immSelT;

endpackage

// File: verilog/instrFieldsIf.sv
`timescale 1ns/100ps

interface instrFieldsIf;
    import controlPkg::*;

    opcodeT                 opcode;
    logic [funct3Width-1:0] funct3;
    logic [funct7Width-1:0] funct7;
    logic                   zero;   // ALU zero flag

    modport fsmSide (input opcode);

    modport outputSide (input opcode, input funct3, input zero);

    modport aluSide (input funct3, input funct7);

endinterface

// File: verilog/controlFsm.sv
`timescale 1ns/100ps

module controlFsm (
    input  logic            clk,
    input  logic            reset,
    instrFieldsIf.fsmSide   fields,
    output controlPkg::stateT state
);
    import controlPkg::*;

    stateT stateNext;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= fetch;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = fetch;
        case (state)
            fetch:          stateNext = fetchWait;
            fetchWait:      stateNext = decodeWait;
            decodeWait:     stateNext = decode;
            decode: begin
                case (fields.opcode)
                    opRtype:  stateNext = rtypeExec;
                    opItype:  stateNext = immExec;
                    opLoad:   stateNext = memAddr;
                    opStore:  stateNext = memAddr;
                    opBranch: stateNext = branchComplete;
                    opJal:    stateNext = jalExec;
                    opJalr:   stateNext = jalrExec;
                    opLui:    stateNext = luiWriteback;
                    opAuipc:  stateNext = auipcExec;
                    default:  stateNext = fetch; // Unknown opcode, skip it
                endcase
            end

            // ALU flows share the writeback state
            rtypeExec:      stateNext = aluWriteback;
            immExec:        stateNext = aluWriteback;
            auipcExec:      stateNext = aluWriteback;
            aluWriteback:   stateNext = fetch;

            // Jumps update PC first, then compute the link value
            jalExec:        stateNext = jalLink;
            jalLink:        stateNext = aluWriteback;
            jalrExec:       stateNext = jalrLink;
            jalrLink:       stateNext = aluWriteback;

            branchComplete: stateNext = fetch;
            luiWriteback:   stateNext = fetch;

            memAddr: begin
                if (fields.opcode == opLoad) begin
                    stateNext = loadAccess;
                end else if (fields.opcode == opStore) begin
                    stateNext = storeAccess;
                end else begin
                    stateNext = fetch;
                end
            end
            loadAccess:     stateNext = loadWait;
            loadWait:       stateNext = loadWriteback;
            loadWriteback:  stateNext = fetch;
            storeAccess:    stateNext = fetch;
            default:        stateNext = fetch;
        endcase
    end

    // Register never holds an encoding outside the state set
    stateLegal: assert property (@(posedge clk) disable iff (reset)
        state inside {fetch, fetchWait, decodeWait, decode, rtypeExec, immExec,
                      aluWriteback, jalExec, jalLink, jalrExec, jalrLink,
                      branchComplete, memAddr, loadAccess, loadWait,
                      loadWriteback, storeAccess, luiWriteback, auipcExec})
        else $error("controlFsm: illegal state %h", state);

endmodule

// File: verilog/controlOutputs.sv
`timescale 1ns/100ps

module controlOutputs (
    input  logic                      clk,
    input  logic                      reset,
    input  controlPkg::stateT         state,
    instrFieldsIf.outputSide          fields,
    output logic                      pcEnable,
    output logic                      instrRegEnable,
    output logic                      instrOrData,
    output logic                      oldPcEnable,
    output controlPkg::immSelT        immSrc,
    output controlPkg::srcASelT       aluSrcA,
    output controlPkg::srcBSelT       aluSrcB,
    output controlPkg::resultSelT     resultSrc,
    output logic                      memWrite,
    output logic                      regWrite,
    output controlPkg::aluOpT         aluOp
);
    import controlPkg::*;

    logic branchTaken;

    // Condition from funct3 and the zero flag of the compare
    always_comb begin
        case (fields.funct3)
            3'b000:  branchTaken = fields.zero;  // BEQ
            3'b001:  branchTaken = !fields.zero; // BNE
            3'b100:  branchTaken = !fields.zero; // BLT
            3'b101:  branchTaken = !fields.zero; // BGE
            3'b110:  branchTaken = !fields.zero; // BLTU
            3'b111:  branchTaken = !fields.zero; // BGEU
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        pcEnable       = 1'b0;
        instrRegEnable = 1'b0;
        instrOrData    = 1'b0;   // Instruction address by default
        oldPcEnable    = 1'b0;
        immSrc         = immI;
        aluSrcA        = srcAPc;
        aluSrcB        = srcBRegB;
        resultSrc      = resultAluOut;
        memWrite       = 1'b0;
        regWrite       = 1'b0;
        aluOp          = aluAdd;

        case (state)
            fetch: begin
                // PC + 4 on the live ALU result
                resultSrc = resultAluResult;
                aluSrcB   = srcBFour;
            end
            fetchWait: begin
                instrRegEnable = 1'b1;
                pcEnable       = 1'b1;
                oldPcEnable    = 1'b1;
            end
            decode: begin
                // Precompute the jump or branch target into ALU out
                aluSrcA = srcAOldPc;
                aluSrcB = srcBImm;
                if (fields.opcode == opBranch) begin
                    immSrc = immB;
                end else begin
                    immSrc = immJ;
                end
            end
            rtypeExec: begin
                aluSrcA = srcARegA;
                aluOp   = aluRegReg;
            end
            immExec: begin
                aluSrcA = srcARegA;
                aluSrcB = srcBImm;
                aluOp   = aluRegImm;
            end
            aluWriteback: begin
                regWrite = 1'b1;
            end
            jalExec: begin
                pcEnable = 1'b1;         // Target from ALU out
                aluSrcA  = srcAOldPc;
                aluSrcB  = srcBImm;
            end
            jalLink, jalrLink: begin
                aluSrcA = srcAOldPc;     // Link value old PC + 4
                aluSrcB = srcBFour;
            end
            jalrExec: begin
                pcEnable  = 1'b1;
                aluSrcA   = srcARegA;
                aluSrcB   = srcBImm;
                resultSrc = resultAluResult;
            end
            branchComplete: begin
                aluSrcA  = srcARegA;
                aluOp    = aluBranch;
                pcEnable = branchTaken;
            end
            memAddr: begin
                aluSrcA = srcARegA;
                aluSrcB = srcBImm;
                if (fields.opcode == opLoad) begin
                    immSrc = immI;
                end else begin
                    immSrc = immS;
                end
            end
            loadAccess, loadWait: begin
                instrOrData = 1'b1;
            end
            loadWriteback: begin
                resultSrc = resultMemData;
                regWrite  = 1'b1;
            end
            storeAccess: begin
                instrOrData = 1'b1;
                memWrite    = 1'b1;
            end
            luiWriteback: begin
                regWrite  = 1'b1;
                resultSrc = resultImm;
                immSrc    = immU;
            end
            auipcExec: begin
                aluSrcA = srcAOldPc;
                aluSrcB = srcBImm;
                immSrc  = immU;
            end
            default: begin
            end
        endcase
    end

    // Store address must come from the data side of the address mux
    storeUsesData: assert property (@(posedge clk) disable iff (reset)
        memWrite |-> instrOrData)
        else $error("controlOutputs: memWrite without instrOrData");

    noWriteClash: assert property (@(posedge clk) disable iff (reset)
        !(regWrite && memWrite))
        else $error("controlOutputs: regWrite and memWrite together");

    // One instruction load per instruction
    irPulseSingle: assert property (@(posedge clk) disable iff (reset)
        instrRegEnable |=> !instrRegEnable)
        else $error("controlOutputs: instrRegEnable held two cycles");

endmodule

// File: verilog/aluDecoder.sv
`timescale 1ns/100ps

module aluDecoder (
    input  controlPkg::aluOpT   aluOp,
    instrFieldsIf.aluSide       fields,
    output controlPkg::aluFuncT aluControl
);
    import controlPkg::*;

    logic altFunc;

    assign altFunc = fields.funct7[5]; // Selects sub, sra and srai

    always_comb begin
        aluControl = funcAdd;
        case (aluOp)
            aluAdd: aluControl = funcAdd;
            aluBranch: begin
                case (fields.funct3)
                    3'b000:  aluControl = funcSub;  // BEQ
                    3'b001:  aluControl = funcSub;  // BNE
                    3'b100:  aluControl = funcSlt;  // BLT
                    3'b101:  aluControl = funcGe;   // BGE
                    3'b110:  aluControl = funcSltu; // BLTU
                    3'b111:  aluControl = funcGeu;  // BGEU
                    default: aluControl = funcSub;
                endcase
            end
            aluRegReg: begin
                case (fields.funct3)
                    3'b000:  aluControl = altFunc ? funcSub : funcAdd;
                    3'b001:  aluControl = funcSll;
                    3'b010:  aluControl = funcSlt;
                    3'b011:  aluControl = funcSltu;
                    3'b100:  aluControl = funcXor;
                    3'b101:  aluControl = altFunc ? funcSra : funcSrl;
                    3'b110:  aluControl = funcOr;
                    3'b111:  aluControl = funcAnd;
                    default: aluControl = funcAdd;
                endcase
            end
            aluRegImm: begin
                // Shift-immediate forms have their own codes
                case (fields.funct3)
                    3'b000:  aluControl = funcAdd;
                    3'b001:  aluControl = funcSlli;
                    3'b010:  aluControl = funcSlt;
                    3'b011:  aluControl = funcSltu;
                    3'b100:  aluControl = funcXor;
                    3'b101:  aluControl = altFunc ? funcSrai : funcSrli;
                    3'b110:  aluControl = funcOr;
                    3'b111:  aluControl = funcAnd;
                    default: aluControl = funcAdd;
                endcase
            end
            default: aluControl = funcAdd;
        endcase
    end

endmodule

// File: verilog/multiCycleControl.sv
`timescale 1ns/100ps

module multiCycleControl (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                zero,
    input  logic [6:0]                          opcode,
    input  logic [controlPkg::funct3Width-1:0]  funct3,
    input  logic [controlPkg::funct7Width-1:0]  funct7,
    output logic                                pcEnable,
    output logic                                instrRegEnable,
    output logic                                instrOrData,
    output logic                                oldPcEnable,
    output controlPkg::immSelT                  immSrc,
    output controlPkg::srcASelT                 aluSrcA,
    output controlPkg::srcBSelT                 aluSrcB,
    output controlPkg::resultSelT               resultSrc,
    output logic                                memWrite,
    output logic                                regWrite,
    output controlPkg::aluFuncT                 aluControl
);
    import controlPkg::*;

    stateT state;
    aluOpT aluOp;

    instrFieldsIf fields ();

    // Fields from the datapath instruction register
    assign fields.opcode = opcodeT'(opcode);
    assign fields.funct3 = funct3;
    assign fields.funct7 = funct7;
    assign fields.zero   = zero;

    controlFsm fsm (
        .clk    (clk),
        .reset  (reset),
        .fields (fields.fsmSide),
        .state  (state)
    );

    controlOutputs outputs (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .fields         (fields.outputSide),
        .pcEnable       (pcEnable),
        .instrRegEnable (instrRegEnable),
        .instrOrData    (instrOrData),
        .oldPcEnable    (oldPcEnable),
        .immSrc         (immSrc),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .resultSrc      (resultSrc),
        .memWrite       (memWrite),
        .regWrite       (regWrite),
        .aluOp          (aluOp)
    );

    aluDecoder aluDec (
        .aluOp      (aluOp),
        .fields     (fields.aluSide),
        .aluControl (aluControl)
    );

endmodule

// File: sim/clockGen.sv
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic reset
);
    localparam int resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0; // Released just after an edge
    end

endmodule

// File: sim/controlTb.sv
`timescale 1ns/100ps

module controlTb;
    import controlPkg::*;

    localparam int numInstr      = 300;
    localparam int timeoutCycles = numInstr * 8 + 100;

    // ALU codes indexed by {funct7[5], funct3}
    localparam logic [3:0] rtypeTable [16] = '{
        funcAdd, funcSll, funcSlt, funcSltu, funcXor, funcSrl, funcOr, funcAnd,
        funcSub, funcSll, funcSlt, funcSltu, funcXor, funcSra, funcOr, funcAnd};
    localparam logic [3:0] itypeTable [16] = '{
        funcAdd, funcSlli, funcSlt, funcSltu, funcXor, funcSrli, funcOr, funcAnd,
        funcAdd, funcSlli, funcSlt, funcSltu, funcXor, funcSrai, funcOr, funcAnd};
    localparam logic [6:0] keptOpcodes [9] = '{
        opRtype, opItype, opLoad, opStore, opBranch, opJal, opJalr, opLui, opAuipc};
    localparam logic [6:0] unknownOpcodes [3] = '{7'b1110011, 7'b0001111, 7'b0000000};

    logic      clk;
    logic      reset;
    logic      zero;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic      pcEnable;
    logic      instrRegEnable;
    logic      instrOrData;
    logic      oldPcEnable;
    logic      memWrite;
    logic      regWrite;
    immSelT    immSrc;
    srcASelT   aluSrcA;
    srcBSelT   aluSrcB;
    resultSelT resultSrc;
    aluFuncT   aluControl;

    int cycleCount      = 0;
    int sinceReset      = 0;
    bit pulseSeen       = 1'b0;
    int checkedCount    = 0;
    int takenBranches   = 0;
    int untakenBranches = 0;
    int winCycles;      // Cycles since the last instruction load
    int regWrites;
    int memWrites;
    int pcPulses;
    int dataCycles;
    int firstData;
    int lastData;
    int aluChecks;

    clockGen clocks (.clk(clk), .reset(reset));

    multiCycleControl DUT (
        .clk(clk), .reset(reset), .zero(zero), .opcode(opcode), .funct3(funct3),
        .funct7(funct7), .pcEnable(pcEnable), .instrRegEnable(instrRegEnable),
        .instrOrData(instrOrData), .oldPcEnable(oldPcEnable), .immSrc(immSrc),
        .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .resultSrc(resultSrc),
        .memWrite(memWrite), .regWrite(regWrite), .aluControl(aluControl)
    );

    function automatic int flowLength(logic [6:0] op);
        case (op)
            opRtype, opItype, opAuipc, opStore: return 6;
            opLoad:                             return 8;
            opJal, opJalr:                      return 7;
            opBranch, opLui:                    return 5;
            default:                            return 4; // Straight back to fetch
        endcase
    endfunction

    function automatic int regWriteCount(logic [6:0] op);
        case (op)
            opRtype, opItype, opLoad, opJal, opJalr, opLui, opAuipc: return 1;
            default:                                                 return 0;
        endcase
    endfunction

    // RV32I immediate format of each instruction
    function automatic immSelT immFormat(logic [6:0] op);
        case (op)
            opStore:        return immS;
            opBranch:       return immB;
            opLui, opAuipc: return immU;
            opJal:          return immJ;
            default:        return immI;
        endcase
    endfunction

    // Redirects of the PC after the fetch increment
    function automatic int pcPulseCount(logic [6:0] op, logic [2:0] f3, logic z);
        if (op == opJal || op == opJalr) begin
            return 1;
        end
        if (op == opBranch && ((f3 == 3'd0 && z) ||
                               (f3 inside {3'd1, 3'd4, 3'd5, 3'd6, 3'd7} && !z))) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic clearCounters();
        winCycles  = 0;
        regWrites  = 0;
        memWrites  = 0;
        pcPulses   = 0;
        dataCycles = 0;
        firstData  = 0;
        lastData   = 0;
        aluChecks  = 0;
    endtask

    task automatic sampleCycle();
        assert (!(regWrite && memWrite)) else failRun("regWrite and memWrite high together");
        assert (!oldPcEnable)
            else failRun($sformatf("mismatch oldPcEnable outside fetch: got %h expected %h",
                                   oldPcEnable, 1'b0));
        if (regWrite) begin
            regWrites++;
            assert (opcode != opLoad || resultSrc == resultMemData)
                else failRun($sformatf("mismatch resultSrc on load write: got %h expected %h",
                                       resultSrc, resultMemData));
        end
        if (memWrite) begin
            memWrites++;
            assert (instrOrData)
                else failRun($sformatf("mismatch instrOrData on store: got %h expected %h",
                                       instrOrData, 1'b1));
        end
        if (pcEnable) pcPulses++;
        if (instrOrData) begin
            if (dataCycles == 0) firstData = winCycles;
            lastData = winCycles;
            dataCycles++;
        end
        // Cycles where the immediate feeds this instruction's own operation
        if ((aluSrcA == srcARegA && aluSrcB == srcBImm) || resultSrc == resultImm ||
                (opcode == opBranch && aluSrcA == srcAOldPc && aluSrcB == srcBImm)) begin
            assert (immSrc == immFormat(opcode))
                else failRun($sformatf("mismatch immSrc, opcode %h: got %h expected %h",
                                       opcode, immSrc, immFormat(opcode)));
        end
        if (opcode == opRtype && aluSrcA == srcARegA && aluSrcB == srcBRegB) begin
            aluChecks++;
            assert (aluControl == rtypeTable[{funct7[5], funct3}])
                else failRun($sformatf("mismatch aluControl R-type f3 %h f7 %h: got %h expected %h",
                                       funct3, funct7, aluControl, rtypeTable[{funct7[5], funct3}]));
        end
        if (opcode == opItype && aluSrcA == srcARegA && aluSrcB == srcBImm) begin
            aluChecks++;
            assert (aluControl == itypeTable[{funct7[5], funct3}])
                else failRun($sformatf("mismatch aluControl I-type f3 %h f7 %h: got %h expected %h",
                                       funct3, funct7, aluControl, itypeTable[{funct7[5], funct3}]));
        end
    endtask

    // Runs on the instruction load that ends the current flow
    task automatic checkInstruction();
        int expPc;
        expPc = pcPulseCount(opcode, funct3, zero);
        assert (winCycles == flowLength(opcode))
            else failRun($sformatf("mismatch instrRegEnable interval, opcode %h: got %h expected %h",
                                   opcode, winCycles, flowLength(opcode)));
        assert (regWrites == regWriteCount(opcode))
            else failRun($sformatf("mismatch regWrite pulses, opcode %h: got %h expected %h",
                                   opcode, regWrites, regWriteCount(opcode)));
        assert (memWrites == ((opcode == opStore) ? 1 : 0))
            else failRun($sformatf("mismatch memWrite pulses, opcode %h: got %h expected %h",
                                   opcode, memWrites, (opcode == opStore) ? 1 : 0));
        assert (pcPulses == expPc)
            else failRun($sformatf("mismatch pcEnable pulses, opcode %h f3 %h zero %h: got %h expected %h",
                                   opcode, funct3, zero, pcPulses, expPc));
        if (opcode == opLoad) begin
            assert (dataCycles == 2)
                else failRun($sformatf("mismatch instrOrData cycles in load: got %h expected %h",
                                       dataCycles, 2));
            assert (lastData == firstData + 1) else failRun("load data cycles are not adjacent");
        end
        if (opcode == opRtype || opcode == opItype) begin
            assert (aluChecks == 1) else failRun("ALU execute cycle missing or repeated");
        end
        if (opcode == opBranch && expPc == 1) takenBranches++;
        if (opcode == opBranch && expPc == 0) untakenBranches++;
    endtask

    task automatic waitForFetch();
        do @(negedge clk); while (!instrRegEnable);
    endtask

    task automatic applyInstruction();
        int pick;
        pick = $urandom_range(0, 19);
        if (pick < 18) begin
            opcode = keptOpcodes[pick / 2];
        end else begin
            opcode = unknownOpcodes[$urandom_range(0, 2)]; // Rare unknown opcode
        end
        funct3 = $urandom_range(0, 7);
        funct7 = $urandom_range(0, 127);
        zero   = $urandom_range(0, 1);
    endtask

    // Outputs are sampled mid-cycle, away from both edges
    always @(negedge clk) begin
        if (reset) begin
            assert (!pcEnable && !memWrite && !regWrite && !instrRegEnable && !oldPcEnable)
                else failRun("control outputs active while reset is asserted");
        end else if (!pulseSeen) begin
            sinceReset++;
            assert (instrRegEnable || (!pcEnable && !memWrite && !regWrite && !oldPcEnable))
                else failRun("control outputs active right after reset");
            if (instrRegEnable) begin
                assert (sinceReset == 2)
                    else failRun($sformatf("mismatch first instrRegEnable cycle: got %h expected %h",
                                           sinceReset, 2));
                assert (oldPcEnable)
                    else failRun($sformatf("mismatch oldPcEnable at fetch: got %h expected %h",
                                           oldPcEnable, 1'b1));
                pulseSeen = 1'b1;
                clearCounters();
            end
        end else begin
            winCycles++;
            if (instrRegEnable) begin
                assert (oldPcEnable)
                    else failRun($sformatf("mismatch oldPcEnable at fetch: got %h expected %h",
                                           oldPcEnable, 1'b1));
                checkInstruction();
                checkedCount++;
                clearCounters();
            end else begin
                sampleCycle();
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            failRun($sformatf("timeout, run not finished after %0d cycles", timeoutCycles));
        end
    end

    initial begin
        void'($urandom(32'h2e66));
        opcode = 7'h00;
        funct3 = '0;
        funct7 = '0;
        zero   = 1'b0;
        for (int n = 0; n < numInstr; n++) begin
            waitForFetch();
            @(posedge clk);
            #1;
            applyInstruction(); // Held until the next instruction load
        end
        waitForFetch();
        @(posedge clk);
        if (checkedCount != numInstr) begin
            failRun("not every instruction was checked");
        end else if (takenBranches == 0 || untakenBranches == 0) begin
            failRun("branch stimulus never reached both outcomes");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: vlog.f
verilog/controlPkg.sv
verilog/instrFieldsIf.sv
verilog/controlFsm.sv
verilog/controlOutputs.sv
verilog/aluDecoder.sv
verilog/multiCycleControl.sv
sim/clockGen.sv
sim/controlTb.sv
